/* nfu_macros.svh */
`ifndef NFU_MACROS_SVH
`define NFU_MACROS_SVH

// Value width of products and sums
`define NFU_W 16

// Products per group and number of groups
`define NFU_TN 4
`define NFU_G 4

// Sparse routing limits
`define NFU_OUT_LIMIT 2
`define NFU_IN_LIMIT 2

// L1 select indexes a group's Tn products
`define NFU_L1_SEL_W 2
// L2 select indexes the pool of G*OUT_LIMIT candidates
`define NFU_L2_SEL_W 3

`endif

/* nfu_pkg.sv */
`default_nettype none
`include "nfu_macros.svh"

package nfu_pkg;

    // Accumulator operation
    typedef enum logic {
        NFU_OP_ACC  = 1'b0,
        NFU_OP_LOAD = 1'b1
    } nfu_op_e;

    // Named signed type so that packed array elements stay signed
    typedef logic signed [`NFU_W-1:0] nfu_val_t;

    // All products of one strobe, indexed [group][product]
    typedef struct packed {
        nfu_val_t [`NFU_G-1:0][`NFU_TN-1:0] p;
    } prod_bus_t;

    // Two-level select lines for the sparse router
    typedef struct packed {
        // Own products that each group sends to the pool
        logic [`NFU_G-1:0][`NFU_OUT_LIMIT-1:0][`NFU_L1_SEL_W-1:0] l1_sel;
        // Pool candidate taken by each group lane
        logic [`NFU_G-1:0][`NFU_IN_LIMIT-1:0][`NFU_L2_SEL_W-1:0]  l2_sel;
        // A cleared lane enable contributes zero
        logic [`NFU_G-1:0][`NFU_IN_LIMIT-1:0]                     l2_en;
    } route_sel_t;

    // One value per group
    typedef struct packed {
        nfu_val_t [`NFU_G-1:0] s;
    } group_sum_t;

    // Control that travels with the data
    typedef struct packed {
        nfu_op_e    op;
        group_sum_t partial;
    } nfu_ctrl_t;

endpackage

`default_nettype wire

/* nfu_dense_tree.sv */
`default_nettype none
`include "nfu_macros.svh"

module nfu_dense_tree
    import nfu_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_valid,
    input  prod_bus_t  i_prod,
    output logic       o_valid,
    output group_sum_t o_dense
);

    localparam int PAIRS = `NFU_TN / 2;

    nfu_val_t [`NFU_G-1:0][PAIRS-1:0] pair_sum;
    group_sum_t                       dense_d;

    // First tree level adds adjacent products in pairs
    always_comb begin
        for (int g = 0; g < `NFU_G; g++) begin
            for (int i = 0; i < PAIRS; i++) begin
                pair_sum[g][i] = i_prod.p[g][2*i] + i_prod.p[g][2*i+1];
            end
        end
    end

    // Second level joins the pair sums of each group
    always_comb begin
        for (int g = 0; g < `NFU_G; g++) begin
            dense_d.s[g] = '0;
            for (int i = 0; i < PAIRS; i++) begin
                dense_d.s[g] = dense_d.s[g] + pair_sum[g][i];
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    // Group sums are only captured with a strobe
    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_dense <= dense_d;
        end
    end

endmodule

`default_nettype wire

/* nfu_sparse_router.sv */
`default_nettype none
`include "nfu_macros.svh"

module nfu_sparse_router
    import nfu_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_valid,
    input  prod_bus_t  i_prod,
    input  route_sel_t i_route,
    output logic       o_valid,
    output group_sum_t o_sparse
);

    localparam int POOL = `NFU_G * `NFU_OUT_LIMIT;

    nfu_val_t [POOL-1:0]                          pool;
    nfu_val_t [`NFU_G-1:0][`NFU_IN_LIMIT-1:0]     lane;
    group_sum_t                                   sparse_d;

    // In L1 each group offers OUT_LIMIT of its own products to the pool
    always_comb begin
        for (int k = 0; k < `NFU_G; k++) begin
            for (int j = 0; j < `NFU_OUT_LIMIT; j++) begin
                pool[k*`NFU_OUT_LIMIT + j] = i_prod.p[k][i_route.l1_sel[k][j]];
            end
        end
    end

    // In L2 each lane picks from the shared pool
    always_comb begin
        for (int g = 0; g < `NFU_G; g++) begin
            for (int i = 0; i < `NFU_IN_LIMIT; i++) begin
                if (i_route.l2_en[g][i]) begin
                    lane[g][i] = pool[i_route.l2_sel[g][i]];
                end else begin
                    lane[g][i] = '0;
                end
            end
        end
    end

    // Lane sum per group wraps at W bits
    always_comb begin
        for (int g = 0; g < `NFU_G; g++) begin
            sparse_d.s[g] = '0;
            for (int i = 0; i < `NFU_IN_LIMIT; i++) begin
                sparse_d.s[g] = sparse_d.s[g] + lane[g][i];
            end
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (i_valid) begin
            o_sparse <= sparse_d;
        end
    end

    // A strobe gives an output one cycle later and all masked lanes route zero
    sparse_valid_delay: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_valid |=> o_valid && (($past(i_route.l2_en) != '0) || (o_sparse == '0))
    );

endmodule

`default_nettype wire

/* nfu_accumulate.sv */
`default_nettype none
`include "nfu_macros.svh"

module nfu_accumulate
    import nfu_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    // Valid from the dense tree
    input  logic       i_valid,
    // Valid from the sparse router for the alignment check
    input  logic       i_sparse_valid,
    input  group_sum_t i_dense,
    input  group_sum_t i_sparse,
    input  nfu_ctrl_t  i_ctrl,
    output logic       o_valid,
    output group_sum_t o_sum
);

    nfu_ctrl_t  ctrl_q;
    group_sum_t sum_q;
    group_sum_t base;
    group_sum_t sum_d;

    // Control waits one cycle to meet the stage-2 sums
    always_ff @(posedge clk) begin
        ctrl_q <= i_ctrl;
    end

    // Base is either the external partial sum or the held value
    always_comb begin
        if (ctrl_q.op == NFU_OP_LOAD) begin
            base = ctrl_q.partial;
        end else begin
            base = sum_q;
        end
    end

    always_comb begin
        for (int g = 0; g < `NFU_G; g++) begin
            sum_d.s[g] = base.s[g] + i_dense.s[g] + i_sparse.s[g];
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
            sum_q   <= '0;
        end else begin
            o_valid <= i_valid;
            if (i_valid) begin
                sum_q <= sum_d;
            end
        end
    end

    // Held value is always visible
    assign o_sum = sum_q;

    // Both stage-2 blocks must deliver the same item in the same cycle
    stage2_aligned: assert property (
        @(posedge clk) disable iff (!i_rst_n)
        i_valid == i_sparse_valid
    );

endmodule

`default_nettype wire

/* nfu_top.sv */
`default_nettype none

module nfu_top
    import nfu_pkg::*;
(
    input  logic       clk,
    input  logic       i_rst_n,
    input  logic       i_valid,
    input  nfu_op_e    i_op,
    input  prod_bus_t  i_prod,
    input  route_sel_t i_route,
    input  group_sum_t i_partial,
    output logic       o_valid,
    output group_sum_t o_sum
);

    logic       valid_q;
    prod_bus_t  prod_q;
    route_sel_t route_q;
    nfu_ctrl_t  ctrl_q;

    logic       dense_valid;
    logic       sparse_valid;
    group_sum_t dense_sum;
    group_sum_t sparse_sum;

    // Input register stage
    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= i_valid;
        end
    end

    always_ff @(posedge clk) begin
        prod_q         <= i_prod;
        route_q        <= i_route;
        ctrl_q.op      <= i_op;
        ctrl_q.partial <= i_partial;
    end

    // Dense and sparse paths run side by side in stage 2
    nfu_dense_tree u_dense_tree (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_valid (valid_q),
        .i_prod  (prod_q),
        .o_valid (dense_valid),
        .o_dense (dense_sum)
    );

    nfu_sparse_router u_sparse_router (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (valid_q),
        .i_prod   (prod_q),
        .i_route  (route_q),
        .o_valid  (sparse_valid),
        .o_sparse (sparse_sum)
    );

    nfu_accumulate u_accumulate (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_valid        (dense_valid),
        .i_sparse_valid (sparse_valid),
        .i_dense        (dense_sum),
        .i_sparse       (sparse_sum),
        .i_ctrl         (ctrl_q),
        .o_valid        (o_valid),
        .o_sum          (o_sum)
    );

endmodule

`default_nettype wire

/* tb_clkgen.sv */
`default_nettype none

module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

endmodule

`default_nettype wire

/* nfu_tb.sv */
`default_nettype none
`include "nfu_macros.svh"

module nfu_tb
    import nfu_pkg::*;
();

    localparam int CLK_PERIOD = 40;
    localparam int RST_CYCLES = 3;
    localparam int N_DENSE    = 16;
    localparam int N_SPARSE   = 40;
    localparam int N_CHAIN    = 24;
    localparam int N_GAP      = 32;
    localparam int MAX_GAP    = 3;
    // Stimulus cycles of all tests plus room for draining
    localparam int RUN_CYCLES = RST_CYCLES + 8 + N_DENSE + N_SPARSE + N_CHAIN
                              + N_GAP * (2 + MAX_GAP) + 100;

    logic        clk;
    logic        rst_n;
    logic        valid;
    nfu_op_e     op;
    prod_bus_t   prod;
    route_sel_t  route;
    group_sum_t  partial;
    logic        o_valid;
    group_sum_t  o_sum;

    logic [31:0] lfsr;
    group_sum_t  model_sum;
    group_sum_t  held_exp = '0;
    group_sum_t  exp_q[$];
    int          sent_q[$];
    int          cycle = 0;
    int          errors = 0;
    int          checks = 0;

    tb_clkgen #(.PERIOD(CLK_PERIOD)) clkgen_inst (.o_clk(clk));

    nfu_top nfu_top_inst (
        .clk       (clk),
        .i_rst_n   (rst_n),
        .i_valid   (valid),
        .i_op      (op),
        .i_prod    (prod),
        .i_route   (route),
        .i_partial (partial),
        .o_valid   (o_valid),
        .o_sum     (o_sum)
    );

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic rand_item(output prod_bus_t p, output route_sel_t r, output group_sum_t s);
        logic [31:0] v;
        for (int g = 0; g < `NFU_G; g++) begin
            for (int t = 0; t < `NFU_TN; t++) begin
                rand_bits(`NFU_W, v);
                p.p[g][t] = v[`NFU_W-1:0];
            end
            for (int j = 0; j < `NFU_OUT_LIMIT; j++) begin
                rand_bits(`NFU_L1_SEL_W, v);
                r.l1_sel[g][j] = v[`NFU_L1_SEL_W-1:0];
            end
            for (int i = 0; i < `NFU_IN_LIMIT; i++) begin
                rand_bits(`NFU_L2_SEL_W, v);
                r.l2_sel[g][i] = v[`NFU_L2_SEL_W-1:0];
                rand_bits(1, v);
                r.l2_en[g][i] = v[0];
            end
            rand_bits(`NFU_W, v);
            s.s[g] = v[`NFU_W-1:0];
        end
    endtask

    // Reference model sums in 32-bit int and keeps the low W bits
    function automatic group_sum_t model_step(input nfu_op_e op_in, input prod_bus_t p,
                                              input route_sel_t r, input group_sum_t part,
                                              input group_sum_t held);
        group_sum_t res;
        int acc;
        int src;
        int slot;
        for (int g = 0; g < `NFU_G; g++) begin
            acc = (op_in == NFU_OP_LOAD) ? int'(part.s[g]) : int'(held.s[g]);
            for (int t = 0; t < `NFU_TN; t++) begin
                acc = acc + int'(p.p[g][t]);
            end
            // Pool candidate c belongs to group c / OUT_LIMIT
            for (int i = 0; i < `NFU_IN_LIMIT; i++) begin
                src  = int'(r.l2_sel[g][i]) / `NFU_OUT_LIMIT;
                slot = int'(r.l2_sel[g][i]) % `NFU_OUT_LIMIT;
                if (r.l2_en[g][i]) begin
                    acc = acc + int'(p.p[src][r.l1_sel[src][slot]]);
                end
            end
            res.s[g] = acc[`NFU_W-1:0];
        end
        return res;
    endfunction

    task automatic send(input nfu_op_e op_in, input prod_bus_t p, input route_sel_t r,
                        input group_sum_t part);
        model_sum = model_step(op_in, p, r, part, model_sum);
        exp_q.push_back(model_sum);
        sent_q.push_back(cycle);
        valid   = 1'b1;
        op      = op_in;
        prod    = p;
        route   = r;
        partial = part;
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic idle(input int n);
        valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    task automatic finish_test(input string name, input int err_before);
        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        idle(2);
        $display("test %s done, %0d errors", name, errors - err_before);
    endtask

    // Output monitor samples on the falling edge since outputs move on the rising edge
    always @(negedge clk) begin
        group_sum_t e;
        int c;
        if (rst_n) begin
            if (o_valid) begin
                assert (exp_q.size() != 0) else begin
                    $display("Output strobe at %0t arrived with no item in flight", $time);
                    errors++;
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    c = sent_q.pop_front();
                    checks++;
                    assert (o_sum == e) else begin
                        $display("FAILED at %0t: o_sum %h, expected %h", $time, o_sum, e);
                        errors++;
                    end
                    assert ((cycle - c) == 3) else begin
                        $display("FAILED at %0t: latency %0d, expected 3", $time, cycle - c);
                        errors++;
                    end
                    held_exp = e;
                end
            end else begin
                checks++;
                assert (o_sum == held_exp) else begin
                    $display("FAILED at %0t: o_sum %h moved without strobe, held %h",
                             $time, o_sum, held_exp);
                    errors++;
                end
            end
        end
    end

    initial begin
        int          e0;
        logic [31:0] v;
        prod_bus_t   p;
        route_sel_t  r;
        group_sum_t  s;
        lfsr      = 32'h409;
        rst_n     = 1'b0;
        valid     = 1'b0;
        op        = NFU_OP_ACC;
        prod      = '0;
        route     = '0;
        partial   = '0;
        model_sum = '0;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e0 = errors;
        idle(4);
        rand_item(p, r, s);
        send(NFU_OP_LOAD, p, r, s);
        finish_test("reset", e0);

        e0 = errors;
        for (int n = 0; n < N_DENSE; n++) begin
            rand_item(p, r, s);
            r.l2_en = '0;
            send(NFU_OP_LOAD, p, r, s);
        end
        finish_test("dense_only", e0);

        e0 = errors;
        for (int n = 0; n < N_SPARSE; n++) begin
            rand_item(p, r, s);
            send(NFU_OP_LOAD, p, r, s);
        end
        finish_test("sparse_routing", e0);

        // Products forced into 0x4000..0x7fff so every step wraps past 16 bits
        e0 = errors;
        rand_item(p, r, s);
        send(NFU_OP_LOAD, p, r, s);
        for (int n = 0; n < N_CHAIN; n++) begin
            rand_item(p, r, s);
            for (int g = 0; g < `NFU_G; g++) begin
                for (int t = 0; t < `NFU_TN; t++) begin
                    p.p[g][t][`NFU_W-1] = 1'b0;
                    p.p[g][t][`NFU_W-2] = 1'b1;
                end
            end
            send(NFU_OP_ACC, p, r, s);
        end
        finish_test("accumulate_chain", e0);

        // First half back to back and second half with idle gaps
        e0 = errors;
        for (int n = 0; n < 2 * N_GAP; n++) begin
            rand_item(p, r, s);
            rand_bits(1, v);
            send(v[0] ? NFU_OP_LOAD : NFU_OP_ACC, p, r, s);
            if (n >= N_GAP) begin
                rand_bits(2, v);
                idle(int'(v[1:0]));
            end
        end
        finish_test("throughput_gaps", e0);

        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * CLK_PERIOD);
        $display("Timeout after %0d cycles, outputs still missing", RUN_CYCLES);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

/* build.f */
+incdir+.
nfu_pkg.sv
nfu_dense_tree.sv
nfu_sparse_router.sv
nfu_accumulate.sv
nfu_top.sv
tb_clkgen.sv
nfu_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := nfu_tb
FILELIST  := build.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard *.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee /dev/stderr | grep -x "sim passed" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
